// File: compile.f
+incdir+.
booth_pkg.sv
booth_ctrl_if.sv
booth_ctrl.sv
booth_step_counter.sv
booth_datapath.sv
booth_mult.sv
tb_booth_mult.sv

// File: Bender.yml
package:
  name: booth_mult

export_include_dirs:
  - .

sources:
  - files:
      - booth_pkg.sv
      - booth_ctrl_if.sv
      - booth_ctrl.sv
      - booth_step_counter.sv
      - booth_datapath.sv
      - booth_mult.sv
  - target: test
    files:
      - tb_booth_mult.sv

// File: tb_booth_mult.sv
`include "booth_defs.svh"

module tb_booth_mult;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int W              = `BOOTH_WIDTH;
    localparam int PROD_W         = `BOOTH_PROD_W;
    localparam int NUM_RANDOM     = 300;
    localparam int ACCEPT_TIMEOUT = 8;
    localparam int RESULT_TIMEOUT = W + 64;

    logic              clk;
    logic              rst;
    logic              src_valid;
    logic              dest_ready;
    logic [W-1:0]      multiplicand;
    logic [W-1:0]      multiplier;
    logic              src_ready;
    logic              dest_valid;
    logic [PROD_W-1:0] product;

    // accepted pairs not yet answered, {multiplicand, multiplier}.
    logic [2*W-1:0]    pair_q[$];

    booth_mult u_booth_mult (
        .clk          (clk),
        .rst          (rst),
        .src_valid    (src_valid),
        .dest_ready   (dest_ready),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .src_ready    (src_ready),
        .dest_valid   (dest_valid),
        .product      (product)
    );

    always #5 clk = ~clk;

    task automatic check_product(input string name, input logic [PROD_W-1:0] exp,
                                 input logic [PROD_W-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected 0x%h, got 0x%h", name, exp, act);
            $display("SOME TESTS FAILED");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected 0x%h, got 0x%h", name, exp, act);
            $display("SOME TESTS FAILED");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("the DUT did not respond in time while %s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "timeout while %s", what);
    endtask

    // signed product of the pair, sign-extended to the product width.
    function automatic logic [PROD_W-1:0] expected_product(input logic [2*W-1:0] pair);
        logic signed [PROD_W-1:0] a_ext;
        logic signed [PROD_W-1:0] b_ext;
        a_ext = {{W{pair[2*W-1]}}, pair[2*W-1:W]};
        b_ext = {{W{pair[W-1]}}, pair[W-1:0]};
        return a_ext * b_ext;
    endfunction

    task automatic drive_noise(input logic valid);
        src_valid    = valid;
        multiplicand = $urandom;
        multiplier   = $urandom;
        dest_ready   = ($urandom_range(0, 2) != 0); // back-pressure a third of the time.
    endtask

    // one full operation: offer, accept, step, result, transfer.
    task automatic run_op(input logic [W-1:0] a, input logic [W-1:0] b);
        int unsigned       gap;
        int unsigned       wait_cnt;
        int unsigned       edges;
        logic              accepted;
        logic              transferred;
        logic              held;
        logic [PROD_W-1:0] prev_product;
        gap = $urandom_range(0, 3);
        repeat (gap) begin
            @(posedge clk);
            #1;
            drive_noise(1'b0);
        end

        @(posedge clk);
        #1;
        drive_noise(1'b1);
        multiplicand = a;
        multiplier   = b;
        accepted     = 1'b0;
        wait_cnt     = 0;
        while (!accepted) begin
            @(negedge clk);
            if (src_ready) begin
                accepted = 1'b1;
                pair_q.push_back({a, b});
            end else begin
                wait_cnt++;
                if (wait_cnt > ACCEPT_TIMEOUT) begin
                    report_timeout("waiting for src_ready");
                end
                @(posedge clk);
                #1;
            end
        end
        @(posedge clk); // accept edge.

        edges       = 0;
        held        = 1'b0;
        transferred = 1'b0;
        while (!transferred) begin
            #1;
            drive_noise($urandom_range(0, 1));
            @(negedge clk);
            check_flag("src_ready", 1'b0, src_ready);
            // first high in the cycle after edge W.
            check_flag("dest_valid", edges >= W, dest_valid);
            if (dest_valid) begin
                if (held) begin
                    check_product("product (held)", prev_product, product);
                end
                check_product("product", expected_product(pair_q[0]), product);
                if (dest_ready) begin
                    transferred = 1'b1;
                end else begin
                    held         = 1'b1;
                    prev_product = product;
                end
            end
            @(posedge clk); // transfer edge once transferred is set.
            if (!transferred) begin
                edges++;
                if (edges > RESULT_TIMEOUT) begin
                    report_timeout("waiting for the product transfer");
                end
            end
        end
        void'(pair_q.pop_front());
        #1;
        drive_noise(1'b0);
        @(negedge clk);
        check_flag("src_ready", 1'b1, src_ready);
        check_flag("dest_valid", 1'b0, dest_valid);
    endtask

    initial begin
        int unsigned  seed_val;
        logic [W-1:0] min_val;
        logic [W-1:0] max_val;
        logic [W-1:0] minus_one;
        clk          = 1'b0;
        rst          = 1'b0;
        src_valid    = 1'b0;
        dest_ready   = 1'b0;
        multiplicand = '0;
        multiplier   = '0;
        seed_val     = $urandom(64658);
        min_val      = {1'b1, {(W-1){1'b0}}};
        max_val      = {1'b0, {(W-1){1'b1}}};
        minus_one    = '1;

        repeat (16) @(posedge clk);
        #1;
        rst = 1'b1;
        @(negedge clk);
        check_flag("src_ready", 1'b1, src_ready);
        check_flag("dest_valid", 1'b0, dest_valid);

        // corner operands.
        run_op(min_val, min_val);
        run_op('0, min_val);
        run_op(max_val, '0);
        run_op(minus_one, minus_one);
        run_op(min_val, minus_one);
        run_op(minus_one, max_val);
        run_op(max_val, max_val);
        run_op(max_val, min_val);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            run_op($urandom, $urandom);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: booth_mult.sv
`include "booth_defs.svh"

module booth_mult (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      src_valid,
    input  logic                      dest_ready,
    input  logic [`BOOTH_WIDTH-1:0]   multiplicand,
    input  logic [`BOOTH_WIDTH-1:0]   multiplier,
    output logic                      src_ready,
    output logic                      dest_valid,
    output logic [`BOOTH_PROD_W-1:0]  product
);

    // steering and status between the three blocks.
    booth_ctrl_if u_ctrl_if ();

    booth_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .src_valid  (src_valid),
        .dest_ready (dest_ready),
        .src_ready  (src_ready),
        .dest_valid (dest_valid),
        .ctl        (u_ctrl_if.ctrl)
    );

    booth_step_counter u_step_counter (
        .clk (clk),
        .rst (rst),
        .cnt (u_ctrl_if.cnt)
    );

    booth_datapath u_datapath (
        .clk          (clk),
        .rst          (rst),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .product      (product),
        .dp           (u_ctrl_if.dp)
    );

endmodule

// File: booth_datapath.sv
`include "booth_defs.svh"

module booth_datapath (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`BOOTH_WIDTH-1:0]   multiplicand,
    input  logic [`BOOTH_WIDTH-1:0]   multiplier,
    output logic [`BOOTH_PROD_W-1:0]  product,
    booth_ctrl_if.dp                  dp
);

    localparam int unsigned W = `BOOTH_WIDTH;

    // accumulator and multiplicand carry one guard bit so that
    // subtracting the most negative multiplicand cannot overflow.
    logic [W:0]   m_q;
    logic [W:0]   a_q;
    logic [W-1:0] q_q;
    logic         q_1_q;

    logic [W:0]   m_ext;
    logic [W:0]   addend;
    logic         carry_in;
    logic [W:0]   sum;

    // sign extension of the incoming multiplicand.
    assign m_ext = {multiplicand[W-1], multiplicand};

    always_ff @(posedge clk) begin
        if (dp.load) begin
            m_q <= m_ext;
        end
    end

    // one adder serves both add and subtract.
    always_comb begin
        case (dp.alu_op)
            booth_pkg::ALU_ADD: begin
                addend   = m_q;
                carry_in = 1'b0;
            end
            booth_pkg::ALU_SUB: begin
                addend   = ~m_q; // two's complement negate.
                carry_in = 1'b1;
            end
            default: begin
                addend   = '0;
                carry_in = 1'b0;
            end
        endcase
    end

    assign sum = a_q + addend + {{W{1'b0}}, carry_in};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            a_q   <= '0;
            q_q   <= '0;
            q_1_q <= 1'b0;
        end else if (dp.load) begin
            a_q   <= '0;
            q_q   <= multiplier;
            q_1_q <= 1'b0;
        end else if (dp.step_en) begin
            // arithmetic shift right of {sum, q, q_1}.
            a_q   <= {sum[W], sum[W:1]};
            q_q   <= {sum[0], q_q[W-1:1]};
            q_1_q <= q_q[0];
        end
    end

    assign dp.q0  = q_q[0];
    assign dp.q_1 = q_1_q;

    // guard bit dropped, the product always fits 2*W bits.
    assign product = {a_q[W-1:0], q_q};

endmodule

// File: booth_step_counter.sv
`include "booth_defs.svh"

module booth_step_counter (
    input  logic        clk,
    input  logic        rst,
    booth_ctrl_if.cnt   cnt
);

    localparam int unsigned CNT_W = `BOOTH_CNT_W;

    logic [CNT_W-1:0] count_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            count_q <= '0;
        end else if (cnt.load) begin
            count_q <= '0; // new operation.
        end else if (cnt.step_en) begin
            count_q <= count_q + 1'b1;
        end
    end

    // high once every operand bit has been recoded.
    assign cnt.done = (count_q == CNT_W'(`BOOTH_WIDTH));

endmodule

// File: booth_ctrl.sv
`include "booth_defs.svh"

module booth_ctrl (
    input  logic         clk,
    input  logic         rst,
    input  logic         src_valid,
    input  logic         dest_ready,
    output logic         src_ready,
    output logic         dest_valid,
    booth_ctrl_if.ctrl   ctl
);

    booth_pkg::ctrl_state_e state_q;
    booth_pkg::ctrl_state_e state_d;
    booth_pkg::alu_op_e     recode_op;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= booth_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // radix-2 recoding of {q0, q_1}.
    always_comb begin
        case ({ctl.q0, ctl.q_1})
            2'b01: begin
                recode_op = booth_pkg::ALU_ADD;
            end
            2'b10: begin
                recode_op = booth_pkg::ALU_SUB;
            end
            default: begin
                recode_op = booth_pkg::ALU_NONE;
            end
        endcase
    end

    always_comb begin
        state_d     = state_q;
        src_ready   = 1'b0;
        dest_valid  = 1'b0;
        ctl.load    = 1'b0;
        ctl.step_en = 1'b0;
        ctl.alu_op  = booth_pkg::ALU_NONE;

        case (state_q)
            booth_pkg::IDLE: begin
                src_ready = 1'b1;
                if (src_valid) begin
                    ctl.load = 1'b1; // operands taken on this edge.
                    state_d  = booth_pkg::BUSY;
                end
            end

            booth_pkg::BUSY: begin
                if (ctl.done) begin
                    dest_valid = 1'b1;
                    if (dest_ready) begin
                        state_d = booth_pkg::IDLE;
                    end else begin
                        state_d = booth_pkg::HOLD;
                    end
                end else begin
                    ctl.step_en = 1'b1;
                    ctl.alu_op  = recode_op;
                end
            end

            booth_pkg::HOLD: begin
                dest_valid = 1'b1; // product frozen, done stays set.
                if (dest_ready) begin
                    state_d = booth_pkg::IDLE;
                end
            end

            default: begin
                state_d = booth_pkg::IDLE;
            end
        endcase
    end

endmodule

// File: booth_ctrl_if.sv
interface booth_ctrl_if;

    logic                load;    // one-cycle operand capture.
    logic                step_en; // one booth step per edge.
    booth_pkg::alu_op_e  alu_op;
    logic                q0;      // low bit of the multiplier register.
    logic                q_1;     // bit shifted out last step.
    logic                done;    // all steps performed.

    modport ctrl (
        output load,
        output step_en,
        output alu_op,
        input  q0,
        input  q_1,
        input  done
    );

    modport dp (
        input  load,
        input  step_en,
        input  alu_op,
        output q0,
        output q_1
    );

    modport cnt (
        input  load,
        input  step_en,
        output done
    );

endinterface

// File: booth_pkg.sv
package booth_pkg;

    // controller states.
    typedef enum logic [1:0] {
        IDLE = 2'b00, // waiting for operands.
        BUSY = 2'b01, // booth steps in progress.
        HOLD = 2'b10  // product waiting for dest_ready.
    } ctrl_state_e;

    // operation on the accumulator before each shift.
    typedef enum logic [1:0] {
        ALU_NONE = 2'b00, // recoding bits 00 or 11.
        ALU_ADD  = 2'b01, // recoding bits 01.
        ALU_SUB  = 2'b10  // recoding bits 10.
    } alu_op_e;

endpackage

// File: booth_defs.svh
`ifndef BOOTH_DEFS_SVH
`define BOOTH_DEFS_SVH

// operand width in bits.
`define BOOTH_WIDTH 8

// product width.
`define BOOTH_PROD_W (2 * `BOOTH_WIDTH)

// step counter width, wide enough to reach BOOTH_WIDTH.
`define BOOTH_CNT_W ($clog2(`BOOTH_WIDTH + 1))

`endif
